/* verilog/rvcPkg.sv */
// ##########################################################
// RVC decoder shared types
// micro-op, access size, register route and immediate kind
// encodings plus the register selector constants
// ##########################################################

`default_nettype none

package rvcPkg;

	localparam int instrWidth = 16;	// one compressed halfword
	localparam int immWidth   = 33;	// sign-extended immediate out

	// 0-31 integer, 32-63 fp (unused), then the specials
	typedef logic [6:0] regIdx_t;

	localparam regIdx_t regZero = 7'd0;
	localparam regIdx_t regLink = 7'd1;
	localparam regIdx_t regSp   = 7'd2;
	localparam regIdx_t regPc   = 7'd64;
	localparam regIdx_t regImm  = 7'd65;	// operand taken from imm

	typedef enum logic [4:0] {
		opInvalid,
		opNop,
		opBreak,
		opAdd,
		opAddW,
		opSub,
		opSubW,
		opAnd,
		opOr,
		opXor,
		opShl,
		opShr,
		opSar,
		opLoadImm,
		opLoad,
		opStore,
		opBranchEq,
		opBranchNe,
		opJump,
		opJumpReg,
		opJumpLinkReg,
		opMove
	} rvcOp_e;

	typedef enum logic [1:0] {
		sizeNone,
		sizeWord,
		sizeDouble
	} memSize_e;

	// how instruction fields land on regN/regM/regO
	typedef enum logic [3:0] {
		routeNone,
		routeFull,		// rd/rs1 [11:7], rs2 [6:2]
		routeFullImm,
		routeShortImm,	// rd' [9:7] in place
		routeShortPair,	// rd' [9:7], rs2' [4:2]
		routeShortMem,	// base [9:7], data [4:2]
		routeSpMem,
		routeSpn,
		routeBranch,
		routePcRel,
		routeJumpReg
	} regRoute_e;

	// one entry per RVC immediate layout
	typedef enum logic [3:0] {
		immNone,
		immCi,
		immLui,
		immSp16,
		immLwsp,
		immLdsp,
		immSwsp,
		immSdsp,
		immLw,
		immLd,
		immSpn,
		immCj,
		immCb
	} immKind_e;

endpackage

`default_nettype wire

/* verilog/rvcOpDecode.sv */
// ##########################################################
// RVC op classifier
// maps a halfword to micro-op, access size, register route
// and immediate layout
// ##########################################################

`timescale 1ns/1ps
`default_nettype none

module rvcOpDecode (
	input  logic [rvcPkg::instrWidth-1:0] instrWord,
	output rvcPkg::rvcOp_e                op,
	output rvcPkg::memSize_e              memSize,
	output rvcPkg::regRoute_e             route,
	output rvcPkg::immKind_e              immKind
);

	logic [2:0] funct3;
	logic [1:0] quadrant;
	logic       rdZero;
	logic       rs2Zero;

	assign funct3   = instrWord[15:13];
	assign quadrant = instrWord[1:0];
	assign rdZero   = (instrWord[11:7] == 5'd0);
	assign rs2Zero  = (instrWord[6:2] == 5'd0);

	always_comb begin
		// anything not matched below stays invalid
		op      = rvcPkg::opInvalid;
		memSize = rvcPkg::sizeNone;
		route   = rvcPkg::routeNone;
		immKind = rvcPkg::immNone;

		casez ({funct3, quadrant})
			5'b000_00: begin
				if (instrWord == '0) begin
					op = rvcPkg::opBreak;	// all-zero halfword
				end else if (instrWord[12:5] != 8'd0) begin
					op      = rvcPkg::opAdd;	// c.addi4spn
					route   = rvcPkg::routeSpn;
					immKind = rvcPkg::immSpn;
				end
			end
			5'b?1?_00: begin
				// c.lw c.ld c.sw c.sd
				op      = funct3[2] ? rvcPkg::opStore : rvcPkg::opLoad;
				memSize = funct3[0] ? rvcPkg::sizeDouble : rvcPkg::sizeWord;
				route   = rvcPkg::routeShortMem;
				immKind = funct3[0] ? rvcPkg::immLd : rvcPkg::immLw;
			end
			5'b000_01, 5'b001_01, 5'b010_01: begin
				route   = rvcPkg::routeFullImm;
				immKind = rvcPkg::immCi;
				case (funct3[1:0])
					2'b00:   op = rvcPkg::opAdd;
					2'b01:   op = rvcPkg::opAddW;
					default: op = rvcPkg::opLoadImm;
				endcase
			end
			5'b011_01: begin
				route = rvcPkg::routeFullImm;
				if (instrWord[11:7] == 5'd2) begin
					op      = rvcPkg::opAdd;	// c.addi16sp
					immKind = rvcPkg::immSp16;
				end else begin
					op      = rvcPkg::opLoadImm;	// c.lui
					immKind = rvcPkg::immLui;
				end
			end
			5'b100_01: begin
				if (instrWord[11:10] != 2'b11) begin
					route   = rvcPkg::routeShortImm;
					immKind = rvcPkg::immCi;	// shamt uses low 6 bits
					case (instrWord[11:10])
						2'b00:   op = rvcPkg::opShr;
						2'b01:   op = rvcPkg::opSar;
						default: op = rvcPkg::opAnd;
					endcase
				end else begin
					route = rvcPkg::routeShortPair;
					case ({instrWord[12], instrWord[6:5]})
						3'b000: op = rvcPkg::opSub;
						3'b001: op = rvcPkg::opXor;
						3'b010: op = rvcPkg::opOr;
						3'b011: op = rvcPkg::opAnd;
						3'b100: op = rvcPkg::opSubW;
						3'b101: op = rvcPkg::opAddW;
						default: begin
							route = rvcPkg::routeNone;	// reserved
						end
					endcase
				end
			end
			5'b101_01: begin
				op      = rvcPkg::opJump;
				route   = rvcPkg::routePcRel;
				immKind = rvcPkg::immCj;
			end
			5'b11?_01: begin
				op      = funct3[0] ? rvcPkg::opBranchNe : rvcPkg::opBranchEq;
				route   = rvcPkg::routeBranch;
				immKind = rvcPkg::immCb;
			end
			5'b000_10: begin
				op      = rvcPkg::opShl;
				route   = rvcPkg::routeFullImm;
				immKind = rvcPkg::immCi;
			end
			5'b?1?_10: begin
				// stack-relative loads and stores
				op      = funct3[2] ? rvcPkg::opStore : rvcPkg::opLoad;
				memSize = funct3[0] ? rvcPkg::sizeDouble : rvcPkg::sizeWord;
				route   = rvcPkg::routeSpMem;
				immKind = funct3[2] ?
					(funct3[0] ? rvcPkg::immSdsp : rvcPkg::immSwsp) :
					(funct3[0] ? rvcPkg::immLdsp : rvcPkg::immLwsp);
			end
			5'b100_10: begin
				if (!rs2Zero) begin
					op    = instrWord[12] ? rvcPkg::opAdd : rvcPkg::opMove;
					route = rvcPkg::routeFull;
				end else if (instrWord[12] && rdZero) begin
					op = rvcPkg::opBreak;	// c.ebreak
				end else if (!rdZero) begin
					op    = instrWord[12] ? rvcPkg::opJumpLinkReg : rvcPkg::opJumpReg;
					route = rvcPkg::routeJumpReg;
				end
			end
			5'b???_11: begin
				op = rvcPkg::opNop;	// 32-bit encoding, not ours
			end
			default: begin
				op = rvcPkg::opInvalid;	// fp forms and reserved slots
			end
		endcase
	end

endmodule

`default_nettype wire

/* verilog/rvcRegMap.sv */
// ##########################################################
// RVC register mapper
// expands compressed fields and routes them onto the
// destination and two source selectors
// ##########################################################

`timescale 1ns/1ps
`default_nettype none

module rvcRegMap (
	input  logic [rvcPkg::instrWidth-1:0] instrWord,
	input  rvcPkg::regRoute_e             route,
	input  rvcPkg::rvcOp_e                op,
	output rvcPkg::regIdx_t               regN,
	output rvcPkg::regIdx_t               regM,
	output rvcPkg::regIdx_t               regO
);

	rvcPkg::regIdx_t fullRd;	// rd/rs1 [11:7]
	rvcPkg::regIdx_t fullRs2;	// rs2 [6:2]
	rvcPkg::regIdx_t shortHi;	// x8-x15 from [9:7]
	rvcPkg::regIdx_t shortLo;	// x8-x15 from [4:2]
	logic            isStore;
	logic            noSrc;	// li and mv read no rd

	assign fullRd  = {2'b00, instrWord[11:7]};
	assign fullRs2 = {2'b00, instrWord[6:2]};
	assign shortHi = {4'b0001, instrWord[9:7]};
	assign shortLo = {4'b0001, instrWord[4:2]};
	assign isStore = (op == rvcPkg::opStore);
	assign noSrc   = (op == rvcPkg::opLoadImm) || (op == rvcPkg::opMove);

	always_comb begin
		regN = rvcPkg::regZero;
		regM = rvcPkg::regZero;
		regO = rvcPkg::regZero;
		case (route)
			rvcPkg::routeFull: begin
				regN = fullRd;
				regM = noSrc ? rvcPkg::regZero : fullRd;
				regO = fullRs2;
			end
			rvcPkg::routeFullImm: begin
				regN = fullRd;
				regM = noSrc ? rvcPkg::regZero : fullRd;
				regO = rvcPkg::regImm;
			end
			rvcPkg::routeShortImm: begin
				regN = shortHi;
				regM = shortHi;
				regO = rvcPkg::regImm;
			end
			rvcPkg::routeShortPair: begin
				regN = shortHi;
				regM = shortHi;
				regO = shortLo;
			end
			rvcPkg::routeShortMem: begin
				regN = shortLo;	// load dest or store data
				regM = shortHi;
				regO = rvcPkg::regImm;
			end
			rvcPkg::routeSpMem: begin
				regN = isStore ? fullRs2 : fullRd;
				regM = rvcPkg::regSp;
				regO = rvcPkg::regImm;
			end
			rvcPkg::routeSpn: begin
				regN = shortLo;
				regM = rvcPkg::regSp;
				regO = rvcPkg::regImm;
			end
			rvcPkg::routeBranch: begin
				regM = shortHi;	// compared against zero
			end
			rvcPkg::routePcRel: begin
				regM = rvcPkg::regPc;
				regO = rvcPkg::regImm;
			end
			rvcPkg::routeJumpReg: begin
				regN = (op == rvcPkg::opJumpLinkReg) ? rvcPkg::regLink : rvcPkg::regZero;
				regM = fullRd;
			end
			default: begin
				regN = rvcPkg::regZero;
			end
		endcase
	end

endmodule

`default_nettype wire

/* verilog/rvcImmExtract.sv */
// ##########################################################
// RVC immediate extractor
// gathers the scattered immediate bits of each layout and
// sign-extends to the output width
// ##########################################################

`timescale 1ns/1ps
`default_nettype none

module rvcImmExtract (
	input  logic [rvcPkg::instrWidth-1:0] instrWord,
	input  rvcPkg::immKind_e              immKind,
	output logic [rvcPkg::immWidth-1:0]   imm
);

	logic [11:0] immSel;	// byte offset, sign at bit 11
	logic [5:0]  luiField;

	assign luiField = {instrWord[12], instrWord[6:2]};

	always_comb begin
		case (immKind)
			rvcPkg::immCi:
				immSel = {{6{instrWord[12]}}, instrWord[12], instrWord[6:2]};
			rvcPkg::immSp16:
				immSel = {{2{instrWord[12]}}, instrWord[12], instrWord[4:3],
					instrWord[5], instrWord[2], instrWord[6], 4'h0};
			rvcPkg::immLwsp:
				immSel = {4'h0, instrWord[3:2], instrWord[12], instrWord[6:4], 2'b00};
			rvcPkg::immLdsp:
				immSel = {3'h0, instrWord[4:2], instrWord[12], instrWord[6:5], 3'b000};
			rvcPkg::immSwsp:
				immSel = {4'h0, instrWord[8:7], instrWord[12:9], 2'b00};
			rvcPkg::immSdsp:
				immSel = {3'h0, instrWord[9:7], instrWord[12:10], 3'b000};
			rvcPkg::immLw:
				immSel = {5'h00, instrWord[5], instrWord[12:10], instrWord[6], 2'b00};
			rvcPkg::immLd:
				immSel = {4'h0, instrWord[6:5], instrWord[12:10], 3'b000};
			rvcPkg::immSpn:
				immSel = {2'b00, instrWord[10:7], instrWord[12:11],
					instrWord[5], instrWord[6], 2'b00};
			rvcPkg::immCj:
				// jump offset bits 11..1
				immSel = {instrWord[12], instrWord[8], instrWord[10:9], instrWord[6],
					instrWord[7], instrWord[2], instrWord[11], instrWord[5:3], 1'b0};
			rvcPkg::immCb:
				immSel = {{3{instrWord[12]}}, instrWord[12], instrWord[6:5],
					instrWord[2], instrWord[11:10], instrWord[4:3], 1'b0};
			default:
				immSel = 12'h000;	// lui handled below
		endcase

		if (immKind == rvcPkg::immLui) begin
			// upper immediate sits at bit 12
			imm = {{(rvcPkg::immWidth - 18){luiField[5]}}, luiField, 12'h000};
		end else begin
			imm = {{(rvcPkg::immWidth - 12){immSel[11]}}, immSel};
		end
	end

endmodule

`default_nettype wire

/* verilog/rvcDecoder.sv */
// ##########################################################
// RVC decoder top
// combinational decode of one halfword per cycle with a
// single output register stage
// ##########################################################

`timescale 1ns/1ps
`default_nettype none

module rvcDecoder (
	input  logic                          clock,
	input  logic                          reset,
	input  logic [rvcPkg::instrWidth-1:0] instrWord,
	output rvcPkg::rvcOp_e                op,
	output rvcPkg::memSize_e              memSize,
	output rvcPkg::regIdx_t               regN,
	output rvcPkg::regIdx_t               regM,
	output rvcPkg::regIdx_t               regO,
	output logic [rvcPkg::immWidth-1:0]   imm
);

	rvcPkg::rvcOp_e              nextOp;
	rvcPkg::memSize_e            nextMemSize;
	rvcPkg::regRoute_e           route;
	rvcPkg::immKind_e            immKind;
	rvcPkg::regIdx_t             nextRegN;
	rvcPkg::regIdx_t             nextRegM;
	rvcPkg::regIdx_t             nextRegO;
	logic [rvcPkg::immWidth-1:0] nextImm;

	rvcOpDecode opDecode_i (
		.instrWord (instrWord),
		.op        (nextOp),
		.memSize   (nextMemSize),
		.route     (route),
		.immKind   (immKind)
	);

	rvcRegMap regMap_i (
		.instrWord (instrWord),
		.route     (route),
		.op        (nextOp),
		.regN      (nextRegN),
		.regM      (nextRegM),
		.regO      (nextRegO)
	);

	rvcImmExtract immExtract_i (
		.instrWord (instrWord),
		.immKind   (immKind),
		.imm       (nextImm)
	);

	// one cycle of latency, new halfword every clock
	always_ff @(posedge clock) begin
		if (reset) begin
			op      <= rvcPkg::opNop;
			memSize <= rvcPkg::sizeNone;
			regN    <= rvcPkg::regZero;
			regM    <= rvcPkg::regZero;
			regO    <= rvcPkg::regZero;
			imm     <= '0;
		end else begin
			op      <= nextOp;
			memSize <= nextMemSize;
			regN    <= nextRegN;
			regM    <= nextRegM;
			regO    <= nextRegO;
			imm     <= nextImm;
		end
	end

endmodule

`default_nettype wire

/* sim/tbClock.sv */
// ##########################################################
// testbench clock and reset
// 20 ns clock, reset held high over the first two edges
// ##########################################################

`timescale 1ns/1ps
`default_nettype none

module tbClock (
	output logic clock,
	output logic reset
);

	always #10 clock = ~clock;

	initial begin
		clock = 1'b0;
		reset = 1'b1;
		repeat (2) @(posedge clock);
		#2 reset = 1'b0;	// released off the edge
	end

endmodule

`default_nettype wire

/* sim/rvcDecoderProps.sv */
// ##########################################################
// RVC decoder output properties
// consistency rules between op, size, selectors and imm
// ##########################################################

`timescale 1ns/1ps
`default_nettype none

module rvcDecoderProps (
	input logic                        clock,
	input logic                        reset,
	input rvcPkg::rvcOp_e              op,
	input rvcPkg::memSize_e            memSize,
	input rvcPkg::regIdx_t             regO,
	input logic [rvcPkg::immWidth-1:0] imm
);

	logic isMemOp;

	assign isMemOp = (op == rvcPkg::opLoad) || (op == rvcPkg::opStore);

	immOperandValid: assert property (@(posedge clock) disable iff (reset)
		(regO == rvcPkg::regImm) |-> (op != rvcPkg::opInvalid))
		else $error("regO selects the immediate on an invalid op");

	invalidImmZero: assert property (@(posedge clock) disable iff (reset)
		(op == rvcPkg::opInvalid) |-> (imm == '0))
		else $error("invalid op carries a nonzero immediate");

	// size only on memory ops
	sizeMatchesMemOp: assert property (@(posedge clock) disable iff (reset)
		((memSize != rvcPkg::sizeNone) == isMemOp))
		else $error("access size does not match load or store op");

endmodule

bind rvcDecoder rvcDecoderProps props_i (
	.clock   (clock),
	.reset   (reset),
	.op      (op),
	.memSize (memSize),
	.regO    (regO),
	.imm     (imm)
);

`default_nettype wire

/* sim/rvcDecoderTb.sv */
// ##########################################################
// RVC decoder testbench
// directed and LFSR halfwords, checked one cycle later
// against a reference decode of the RVC table
// ##########################################################

`timescale 1ns/1ps
`default_nettype none

module rvcDecoderTb;

	localparam int directedCount = 48;
	localparam int randomCount   = 2000;
	localparam int cycleLimit    = directedCount + randomCount + 20;

	logic                        clock;
	logic                        reset;
	logic [15:0]                 instrWord;
	rvcPkg::rvcOp_e              op;
	rvcPkg::memSize_e            memSize;
	rvcPkg::regIdx_t             regN;
	rvcPkg::regIdx_t             regM;
	rvcPkg::regIdx_t             regO;
	logic [rvcPkg::immWidth-1:0] imm;

	logic [15:0] capturedWord;
	logic        checkPending = 1'b0;
	int          errorCount = 0;
	int          checkCount = 0;
	int          cycleCount = 0;
	logic [15:0] lfsrState;

	// quadrant 0, quadrant 1, quadrant 2, quadrant 3
	logic [15:0] directedList [0:directedCount-1] = '{
		16'h0000, 16'h1fe0, 16'h0010, 16'h4188, 16'h6188, 16'hc188, 16'he3fc, 16'h2000,
		16'h8000, 16'ha000,
		16'h0001, 16'h1ffd, 16'h2405, 16'h5ffd, 16'h6101, 16'h7ffd, 16'h6081, 16'h8005,
		16'h8405, 16'h987d, 16'h8c01, 16'h8c21, 16'h8c41, 16'h8c61, 16'h9c01, 16'h9c21,
		16'h9c41, 16'h9c61, 16'ha001, 16'hbffd, 16'hc001, 16'hfffd,
		16'h0002, 16'h1ffe, 16'h2002, 16'h4082, 16'h7ffe, 16'hc006, 16'hfffe, 16'ha002,
		16'h8082, 16'h9082, 16'h9002, 16'h8002, 16'h80aa, 16'h90aa,
		16'hffff, 16'h0003
	};

	tbClock clock_i (
		.clock (clock),
		.reset (reset)
	);

	rvcDecoder dut_i (
		.clock     (clock),
		.reset     (reset),
		.instrWord (instrWord),
		.op        (op),
		.memSize   (memSize),
		.regN      (regN),
		.regM      (regM),
		.regO      (regO),
		.imm       (imm)
	);

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsrStep(input logic [15:0] state);
		logic feedback;
		feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
		return {state[14:0], feedback};
	endfunction

	function automatic void refDecode(
		input  logic [15:0]      w,
		output rvcPkg::rvcOp_e   expOp,
		output rvcPkg::memSize_e expSize,
		output rvcPkg::regIdx_t  expN,
		output rvcPkg::regIdx_t  expM,
		output rvcPkg::regIdx_t  expO,
		output logic [32:0]      expImm
	);
		logic [2:0]      f3;
		rvcPkg::regIdx_t rd;
		rvcPkg::regIdx_t rs2;
		rvcPkg::regIdx_t rdc;	// x8-x15 from [9:7]
		rvcPkg::regIdx_t rsc;	// x8-x15 from [4:2]
		int              ci;
		int              offset;
		f3 = w[15:13];
		rd = 7'(w[11:7]);
		rs2 = 7'(w[6:2]);
		rdc = 7'd8 + 7'(w[9:7]);
		rsc = 7'd8 + 7'(w[4:2]);
		ci = int'({w[12], w[6:2]});
		if (w[12])
			ci = ci - 64;
		offset = 0;
		expOp = rvcPkg::opInvalid;
		expSize = rvcPkg::sizeNone;
		expN = rvcPkg::regZero;
		expM = rvcPkg::regZero;
		expO = rvcPkg::regZero;
		case (w[1:0])
			2'b00: begin
				if (w == 16'h0000) begin
					expOp = rvcPkg::opBreak;
				end else if (f3 == 3'b000 && w[12:5] != 8'd0) begin
					expOp = rvcPkg::opAdd;	// addi4spn
					expN = rsc;
					expM = rvcPkg::regSp;
					expO = rvcPkg::regImm;
					offset = (int'(w[12:11]) << 4) | (int'(w[10:7]) << 6) |
						(int'(w[6]) << 2) | (int'(w[5]) << 3);
				end else if (f3[1]) begin
					expOp = f3[2] ? rvcPkg::opStore : rvcPkg::opLoad;
					expSize = f3[0] ? rvcPkg::sizeDouble : rvcPkg::sizeWord;
					expN = rsc;
					expM = rdc;
					expO = rvcPkg::regImm;
					if (f3[0])
						offset = (int'(w[12:10]) << 3) | (int'(w[6:5]) << 6);
					else
						offset = (int'(w[12:10]) << 3) | (int'(w[6]) << 2) | (int'(w[5]) << 6);
				end
			end
			2'b01: begin
				case (f3)
					3'b000, 3'b001, 3'b010: begin
						expOp = (f3 == 3'b000) ? rvcPkg::opAdd :
							(f3 == 3'b001) ? rvcPkg::opAddW : rvcPkg::opLoadImm;
						expN = rd;
						expM = (f3 == 3'b010) ? rvcPkg::regZero : rd;
						expO = rvcPkg::regImm;
						offset = ci;
					end
					3'b011: begin
						expN = rd;
						expO = rvcPkg::regImm;
						if (rd == rvcPkg::regSp) begin
							expOp = rvcPkg::opAdd;	// addi16sp
							expM = rvcPkg::regSp;
							offset = (int'(w[12]) << 9) | (int'(w[6]) << 4) | (int'(w[5]) << 6) |
								(int'(w[4:3]) << 7) | (int'(w[2]) << 5);
							if (w[12])
								offset = offset - 1024;
						end else begin
							expOp = rvcPkg::opLoadImm;
							offset = ci * 4096;
						end
					end
					3'b100: begin
						expN = rdc;
						expM = rdc;
						if (w[11:10] != 2'b11) begin
							expOp = (w[11:10] == 2'b00) ? rvcPkg::opShr :
								(w[11:10] == 2'b01) ? rvcPkg::opSar : rvcPkg::opAnd;
							expO = rvcPkg::regImm;
							offset = ci;
						end else begin
							case ({w[12], w[6:5]})
								3'b000: expOp = rvcPkg::opSub;
								3'b001: expOp = rvcPkg::opXor;
								3'b010: expOp = rvcPkg::opOr;
								3'b011: expOp = rvcPkg::opAnd;
								3'b100: expOp = rvcPkg::opSubW;
								3'b101: expOp = rvcPkg::opAddW;
								default: begin
									expN = rvcPkg::regZero;
									expM = rvcPkg::regZero;
								end
							endcase
							if (expOp != rvcPkg::opInvalid)
								expO = rsc;
						end
					end
					3'b101: begin
						expOp = rvcPkg::opJump;
						expM = rvcPkg::regPc;
						expO = rvcPkg::regImm;
						offset = (int'(w[12]) << 11) | (int'(w[11]) << 4) | (int'(w[10:9]) << 8) |
							(int'(w[8]) << 10) | (int'(w[7]) << 6) | (int'(w[6]) << 7) |
							(int'(w[5:3]) << 1) | (int'(w[2]) << 5);
						if (w[12])
							offset = offset - 4096;
					end
					default: begin
						expOp = f3[0] ? rvcPkg::opBranchNe : rvcPkg::opBranchEq;
						expM = rdc;
						offset = (int'(w[12]) << 8) | (int'(w[11:10]) << 3) | (int'(w[6:5]) << 6) |
							(int'(w[4:3]) << 1) | (int'(w[2]) << 5);
						if (w[12])
							offset = offset - 512;
					end
				endcase
			end
			2'b10: begin
				if (f3 == 3'b000) begin
					expOp = rvcPkg::opShl;
					expN = rd;
					expM = rd;
					expO = rvcPkg::regImm;
					offset = ci;
				end else if (f3[1]) begin
					expOp = f3[2] ? rvcPkg::opStore : rvcPkg::opLoad;
					expSize = f3[0] ? rvcPkg::sizeDouble : rvcPkg::sizeWord;
					expN = f3[2] ? rs2 : rd;	// store data or load dest
					expM = rvcPkg::regSp;
					expO = rvcPkg::regImm;
					case (f3)
						3'b010: offset = (int'(w[12]) << 5) | (int'(w[6:4]) << 2) | (int'(w[3:2]) << 6);
						3'b011: offset = (int'(w[12]) << 5) | (int'(w[6:5]) << 3) | (int'(w[4:2]) << 6);
						3'b110: offset = (int'(w[12:9]) << 2) | (int'(w[8:7]) << 6);
						default: offset = (int'(w[12:10]) << 3) | (int'(w[9:7]) << 6);
					endcase
				end else if (f3 == 3'b100) begin
					if (rs2 != rvcPkg::regZero) begin
						expOp = w[12] ? rvcPkg::opAdd : rvcPkg::opMove;
						expN = rd;
						expM = w[12] ? rd : rvcPkg::regZero;
						expO = rs2;
					end else if (rd == rvcPkg::regZero) begin
						if (w[12])
							expOp = rvcPkg::opBreak;
					end else begin
						expOp = w[12] ? rvcPkg::opJumpLinkReg : rvcPkg::opJumpReg;
						expN = w[12] ? rvcPkg::regLink : rvcPkg::regZero;
						expM = rd;
					end
				end
			end
			default: begin
				expOp = rvcPkg::opNop;	// 32-bit encoding
			end
		endcase
		expImm = 33'(offset);
	endfunction

	task automatic checkField(input string name, input logic [32:0] got,
		input logic [32:0] expected, input logic [15:0] word);
		checkCount++;
		assert (got === expected) else begin
			$display("mismatch %s: got %h expected %h for instr %h", name, got, expected, word);
			errorCount++;
		end
	endtask

	task automatic driveWord(input logic [15:0] word);
		@(posedge clock);
		#2 instrWord = word;
	endtask

	always @(posedge clock) begin
		checkPending <= !reset;
		capturedWord <= instrWord;
	end

	// outputs settle after the edge, compared mid-cycle
	always @(negedge clock) begin
		rvcPkg::rvcOp_e   expOp;
		rvcPkg::memSize_e expSize;
		rvcPkg::regIdx_t  expN;
		rvcPkg::regIdx_t  expM;
		rvcPkg::regIdx_t  expO;
		logic [32:0]      expImm;
		if (checkPending) begin
			refDecode(capturedWord, expOp, expSize, expN, expM, expO, expImm);
			checkField("op", 33'(op), 33'(expOp), capturedWord);
			checkField("memSize", 33'(memSize), 33'(expSize), capturedWord);
			checkField("regN", 33'(regN), 33'(expN), capturedWord);
			checkField("regM", 33'(regM), 33'(expM), capturedWord);
			checkField("regO", 33'(regO), 33'(expO), capturedWord);
			checkField("imm", imm, expImm, capturedWord);
		end
	end

	always @(posedge clock) begin
		cycleCount++;
		if (cycleCount >= cycleLimit) begin
			$display("run did not finish within %0d cycles", cycleLimit);
			$display("checks %0d errors %0d", checkCount, errorCount);
			$display("Testbench failed");
			$finish;
		end
	end

	initial begin
		logic [15:0] word;
		instrWord = 16'h0000;
		lfsrState = 16'd10;
		wait (reset == 1'b0);
		@(negedge clock);
		checkField("op", 33'(op), 33'(rvcPkg::opNop), instrWord);	// reset values
		checkField("memSize", 33'(memSize), 33'(rvcPkg::sizeNone), instrWord);
		checkField("regN", 33'(regN), 33'd0, instrWord);
		checkField("regM", 33'(regM), 33'd0, instrWord);
		checkField("regO", 33'(regO), 33'd0, instrWord);
		checkField("imm", imm, 33'd0, instrWord);
		for (int idx = 0; idx < directedCount; idx++)
			driveWord(directedList[idx]);
		for (int idx = 0; idx < randomCount; idx++) begin
			word = 16'h0000;
			for (int bitIdx = 0; bitIdx < 16; bitIdx++) begin
				lfsrState = lfsrStep(lfsrState);
				word = {word[14:0], lfsrState[0]};
			end
			driveWord(word);
		end
		repeat (3) @(posedge clock);
		$display("checks %0d errors %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

/* build.f */
verilog/rvcPkg.sv
verilog/rvcOpDecode.sv
verilog/rvcRegMap.sv
verilog/rvcImmExtract.sv
verilog/rvcDecoder.sv
sim/tbClock.sv
sim/rvcDecoderProps.sv
sim/rvcDecoderTb.sv

/* run.sh */
#!/bin/sh
# build and run the RVC decoder testbench with Verilator
rm -f sim.log
verilator --binary --timing --assert --top-module rvcDecoderTb -Mdir obj_dir -f build.f \
	&& ./obj_dir/VrvcDecoderTb > sim.log 2>&1 \
	|| echo "Testbench failed" >> sim.log
cat sim.log
grep -q "Testbench failed" sim.log && exit 1
exit 0
